// ==== hw/tgfx_stream_pkg.sv ====
// Host download stream types
package tgfx_stream_pkg;

	// ==============================
	// Stream from the host
	// ==============================

	typedef struct packed {
		logic        wr;   // Write strobe
		logic [24:0] addr; // Byte address
		logic [15:0] data;
	} stream_word_t;

	typedef struct packed {
		logic       download; // High for the whole transfer
		logic [7:0] index;    // Menu slot of the file
	} stream_ctl_t;

	localparam logic [7:0] CODE_INDEX = 8'hFF; // Cheat file
	localparam logic [4:0] SGX_INDEX  = 5'd2;  // SuperGrafx image, low five bits

	// ==============================
	// Cheat record
	// ==============================

	// Console view, flags on top
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	typedef union packed {
		logic [7:0][15:0] words; // Loader view
		cheat_fields_t    f;     // Console view
	} cheat_rec_t;

	// Word slot inside the record for each stream beat
	typedef enum logic [2:0] {
		SLOT_REP_LO   = 3'd0,
		SLOT_REP_HI   = 3'd1,
		SLOT_CMP_LO   = 3'd2,
		SLOT_CMP_HI   = 3'd3,
		SLOT_ADDR_LO  = 3'd4,
		SLOT_ADDR_HI  = 3'd5,
		SLOT_FLAGS_LO = 3'd6,
		SLOT_FLAGS_HI = 3'd7
	} cheat_word_slot_e;

	// Beat number is byte offset 0..14 divided by two
	function automatic cheat_word_slot_e cheat_slot(input logic [2:0] beat);
		case (beat)
			3'd0: return SLOT_FLAGS_LO;
			3'd1: return SLOT_FLAGS_HI;
			3'd2: return SLOT_ADDR_LO;
			3'd3: return SLOT_ADDR_HI;
			3'd4: return SLOT_CMP_LO;
			3'd5: return SLOT_CMP_HI;
			3'd6: return SLOT_REP_LO;
			default: return SLOT_REP_HI;
		endcase
	endfunction

endpackage

// ==== hw/tgfx_rom_pkg.sv ====
// ROM memory ports and header constants
package tgfx_rom_pkg;

	// ==============================
	// Address widths
	// ==============================

	localparam int ROM_AW   = 24; // Write side, byte address
	localparam int FETCH_AW = 22; // Console read side

	// Copier header in front of some images
	localparam int HDR_OFFSET = 512;

	// ==============================
	// POPULOUS detection
	// ==============================

	// Rows of address bits 23:4 that hold the title
	localparam logic [19:0] POP_ROW_A = 20'h212;
	localparam logic [19:0] POP_ROW_B = 20'h1F2;

	// Expected words at offsets 6, 8, 10 and 12 of the row
	localparam logic [0:3][15:0] POP_SIG = {16'h4F50, 16'h5550, 16'h4F4C, 16'h5355};

	// ==============================
	// Memory ports
	// ==============================

	// Shared write port, one request toggle for both memories
	typedef struct packed {
		logic [ROM_AW-1:0] addr;
		logic [15:0]       data;
		logic              req; // Flips once per write
	} rom_wr_t;

	// Read port, address already offset past any header
	typedef struct packed {
		logic              rd;
		logic [ROM_AW-1:0] addr;
	} rom_rd_t;

endpackage

// ==== hw/rom_loader.sv ====
// Cartridge ROM download loader
`timescale 1ns/100ps

module rom_loader
	import tgfx_stream_pkg::*;
	import tgfx_rom_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  stream_word_t stream,
	input  stream_ctl_t  ctl,
	input  logic         swap_bits,
	input  logic         ddr_wr_ack,
	input  logic         sdr_wr_ack,
	output rom_wr_t      rom_wr,
	output logic         stream_wait,
	output logic         populous,
	output logic         sgx,
	output logic [7:0]   rom_size,
	output logic         header_present
);

	logic              cart_download;
	logic              cart_dl_q;
	logic              dl_start;
	logic              beat;
	logic              both_acked;
	logic [15:0]       beat_data;
	logic              sig_miss;
	logic [ROM_AW-1:0] wr_addr;
	logic [15:0]       wr_data;
	logic              req_tgl;
	logic [1:0]        pop_q; // One flag per 8 KB half, by addr[13]

	function automatic logic [7:0] rev8(input logic [7:0] b);
		logic [7:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i] = b[7-i];
		end
		return r;
	endfunction

	// ==============================
	// Stream decode
	// ==============================

	assign cart_download = ctl.download && (ctl.index != CODE_INDEX);
	assign dl_start      = cart_download && !cart_dl_q;
	assign beat          = stream.wr && cart_download;

	// Bits reversed in each byte, then bytes exchanged
	assign beat_data = swap_bits ? {rev8(stream.data[7:0]), rev8(stream.data[15:8])}
	                             : stream.data;

	// Both memories have caught up with the toggle
	assign both_acked = (req_tgl == ddr_wr_ack) && (req_tgl == sdr_wr_ack);

	// Title check on the two candidate header rows
	always_comb begin
		sig_miss = 1'b0;
		if (wr_addr[ROM_AW-1:4] == POP_ROW_A || wr_addr[ROM_AW-1:4] == POP_ROW_B) begin
			case (wr_addr[3:0])
				4'd6:  sig_miss = (beat_data != POP_SIG[0]);
				4'd8:  sig_miss = (beat_data != POP_SIG[1]);
				4'd10: sig_miss = (beat_data != POP_SIG[2]);
				4'd12: sig_miss = (beat_data != POP_SIG[3]);
				default: sig_miss = 1'b0;
			endcase
		end
	end

	// ==============================
	// Write sequencing
	// ==============================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_dl_q   <= 1'b0;
			stream_wait <= 1'b0;
			req_tgl     <= 1'b0;
			wr_addr     <= '0;
			pop_q       <= 2'b00;
			sgx         <= 1'b0;
		end else begin
			cart_dl_q <= cart_download;
			if (dl_start) begin
				wr_addr <= '0;
				pop_q   <= 2'b11; // Assume a match until a word differs
				sgx     <= (ctl.index[4:0] == SGX_INDEX);
			end else if (beat) begin
				stream_wait <= 1'b1; // Hold the host until both acks
				req_tgl     <= ~req_tgl;
				if (sig_miss) begin
					pop_q[wr_addr[13]] <= 1'b0;
				end
			end else if (stream_wait && both_acked) begin
				stream_wait <= 1'b0;
				wr_addr     <= wr_addr + ROM_AW'(2);
			end
		end
	end

	// Held with the request until the next beat
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			wr_data <= beat_data;
		end
	end

	assign rom_wr = '{addr: wr_addr, data: wr_data, req: req_tgl};

	// ==============================
	// Image info
	// ==============================

	// Bit 9 set means the image carries a 512-byte header
	assign header_present = wr_addr[9];
	assign populous       = pop_q[wr_addr[9]];
	assign rom_size       = wr_addr[ROM_AW-1:16];

endmodule

// ==== hw/cheat_loader.sv ====
// Cheat record loader
`timescale 1ns/100ps

module cheat_loader
	import tgfx_stream_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  stream_word_t stream,
	input  stream_ctl_t  ctl,
	output cheat_rec_t   cheat,
	output logic         cheat_valid,
	output logic         cheat_reset
);

	logic code_wr;
	logic last_word;

	// Only even offsets carry a word
	assign code_wr   = ctl.download && (ctl.index == CODE_INDEX) && stream.wr
	                   && !stream.addr[0];
	assign last_word = (stream.addr[3:0] == 4'd14); // Replace top word

	// Record words, slot picked by the beat number
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat.words[cheat_slot(stream.addr[3:1])] <= stream.data;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_wr && last_word;
			// First word of any download clears the console's code list
			cheat_reset <= ctl.download && stream.wr && (stream.addr == '0);
		end
	end

endmodule

// ==== hw/rom_fetch_router.sv ====
// Console ROM fetch router
`timescale 1ns/100ps

module rom_fetch_router
	import tgfx_rom_pkg::*;
#(
	parameter int FETCH_AW = 22
) (
	input  logic                clk_sys,
	input  logic                arst_n,

	// Console side
	input  logic                fetch_rd,
	input  logic [FETCH_AW-1:0] fetch_addr,
	input  logic                header_present,
	input  logic                use_sdram,
	output logic [7:0]          fetch_data,
	output logic                fetch_rdy,

	// Memory side
	output rom_rd_t             ddr_rd,
	output rom_rd_t             sdr_rd,
	input  logic                ddr_rd_rdy,
	input  logic                sdr_rd_rdy,
	input  logic [7:0]          ddr_rd_data,
	input  logic [7:0]          sdr_rd_data
);

	logic [ROM_AW-1:0] rd_addr;
	logic              use_sdr_q; // Storage of the read in flight

	// Skip the copier header when present
	assign rd_addr = ROM_AW'(fetch_addr)
	                 + (header_present ? ROM_AW'(HDR_OFFSET) : ROM_AW'(0));

	// ==============================
	// Read strobes
	// ==============================

	assign ddr_rd = '{rd: fetch_rd && !use_sdram, addr: rd_addr};
	assign sdr_rd = '{rd: fetch_rd && use_sdram, addr: rd_addr};

	// Keeps the data mux steady while the read completes
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			use_sdr_q <= 1'b0;
		end else if (fetch_rd) begin
			use_sdr_q <= use_sdram;
		end
	end

	// ==============================
	// Return path
	// ==============================

	assign fetch_data = use_sdr_q ? sdr_rd_data : ddr_rd_data;
	assign fetch_rdy  = ddr_rd_rdy && sdr_rd_rdy; // Idle memory holds ready high

endmodule

// ==== hw/tgfx_loader_top.sv ====
// PC Engine loader top level
`timescale 1ns/100ps

module tgfx_loader_top
	import tgfx_stream_pkg::*;
	import tgfx_rom_pkg::*;
(
	input  logic                clk_sys,
	input  logic                arst_n,

	// Host stream
	input  stream_word_t        stream,
	input  stream_ctl_t         ctl,
	input  logic                swap_bits,
	input  logic                use_sdram,
	output logic                stream_wait,

	// ROM write side
	input  logic                ddr_wr_ack,
	input  logic                sdr_wr_ack,
	output rom_wr_t             rom_wr,

	// Image info
	output logic                populous,
	output logic                sgx,
	output logic [7:0]          rom_size,
	output logic                header_present,

	// Cheats
	output cheat_rec_t          cheat,
	output logic                cheat_valid,
	output logic                cheat_reset,

	// Console fetch
	input  logic                fetch_rd,
	input  logic [FETCH_AW-1:0] fetch_addr,
	output logic [7:0]          fetch_data,
	output logic                fetch_rdy,

	// ROM read side
	output rom_rd_t             ddr_rd,
	output rom_rd_t             sdr_rd,
	input  logic                ddr_rd_rdy,
	input  logic [7:0]          ddr_rd_data,
	input  logic                sdr_rd_rdy,
	input  logic [7:0]          sdr_rd_data
);

	rom_loader i_rom_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.stream         (stream),
		.ctl            (ctl),
		.swap_bits      (swap_bits),
		.ddr_wr_ack     (ddr_wr_ack),
		.sdr_wr_ack     (sdr_wr_ack),
		.rom_wr         (rom_wr),
		.stream_wait    (stream_wait),
		.populous       (populous),
		.sgx            (sgx),
		.rom_size       (rom_size),
		.header_present (header_present)
	);

	// Same stream, separate consumer
	cheat_loader i_cheat_loader (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.stream      (stream),
		.ctl         (ctl),
		.cheat       (cheat),
		.cheat_valid (cheat_valid),
		.cheat_reset (cheat_reset)
	);

	rom_fetch_router #(
		.FETCH_AW (FETCH_AW)
	) i_rom_fetch_router (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.fetch_rd       (fetch_rd),
		.fetch_addr     (fetch_addr),
		.header_present (header_present),
		.use_sdram      (use_sdram),
		.ddr_rd         (ddr_rd),
		.sdr_rd         (sdr_rd),
		.ddr_rd_rdy     (ddr_rd_rdy),
		.sdr_rd_rdy     (sdr_rd_rdy),
		.ddr_rd_data    (ddr_rd_data),
		.sdr_rd_data    (sdr_rd_data),
		.fetch_data     (fetch_data),
		.fetch_rdy      (fetch_rdy)
	);

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// ==== bench/tb_checker.sv ====
// Loader reference model and checks
`timescale 1ns/100ps

module tb_checker
	import tgfx_stream_pkg::*;
	import tgfx_rom_pkg::*;
(
	input logic                clk_sys,
	input logic                arst_n,
	input stream_word_t        stream,
	input stream_ctl_t         ctl,
	input logic                swap_bits,
	input logic                use_sdram,
	input logic                ddr_wr_ack,
	input logic                sdr_wr_ack,
	input rom_wr_t             rom_wr,
	input logic                stream_wait,
	input logic                populous,
	input logic                sgx,
	input logic [7:0]          rom_size,
	input logic                header_present,
	input cheat_rec_t          cheat,
	input logic                cheat_valid,
	input logic                cheat_reset,
	input logic                fetch_rd,
	input logic [FETCH_AW-1:0] fetch_addr,
	input rom_rd_t             ddr_rd,
	input rom_rd_t             sdr_rd,
	input logic [7:0]          fetch_data,
	input logic                fetch_rdy
);

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	int err_mark = 0;
	int beats = 0;     // Cart words of the current image
	int rec_cnt = 0;
	int valid_cnt = 0;

	logic [39:0] exp_q[$]; // Expected {addr, data} per write
	logic [15:0] title[4] = '{16'h4F50, 16'h5550, 16'h4F4C, 16'h5355};
	logic [15:0] cw[8];    // Cheat words by beat number
	logic [1:0]  pop = 2'b11;
	logic        exp_sgx = 1'b0;
	logic        prev_cart = 1'b0;
	logic        prev_beat = 1'b0;
	logic        prev_wait = 1'b0;
	logic        prev_req = 1'b0;
	logic        prev_ack_d = 1'b0;
	logic        prev_ack_s = 1'b0;
	logic        exp_reset = 1'b0;
	logic        exp_valid = 1'b0;
	logic        rd_pend = 1'b0;
	logic        rd_low = 1'b0;
	logic [7:0]  rd_exp = 8'h00;

	function automatic logic [15:0] reverse16(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = w[15-i];
		end
		return r;
	endfunction

	task automatic check(input logic ok, input string msg);
		checks++;
		if (!ok) begin
			errors++;
			$display("mismatch at %0t: %s", $time, msg);
		end
	endtask

	// ==============================
	// Per-cycle model
	// ==============================

	always @(posedge clk_sys) begin : model
		logic        cart;
		logic [15:0] d;
		logic [23:0] a;
		logic [39:0] e;
		logic [23:0] want;
		if (arst_n) begin
			cart = ctl.download && (ctl.index != 8'hFF);
			if (cart && !prev_cart) begin
				beats = 0;
				pop = 2'b11;
				exp_sgx = (ctl.index[4:0] == 5'd2);
			end else if (cart && stream.wr) begin
				d = swap_bits ? reverse16(stream.data) : stream.data;
				a = 24'(beats * 2);
				exp_q.push_back({a, d});
				beats++;
				// Title words on either header row
				if ((a[23:4] == 20'h212 || a[23:4] == 20'h1F2) && a[3:0] >= 4'd6
				    && a[3:0] <= 4'd12 && d != title[a[3:1] - 3'd3]) begin
					pop[a[13]] = 1'b0;
				end
			end

			if (rom_wr.req != prev_req) begin
				if (exp_q.size() == 0) begin
					check(1'b0, "write issued with no beat pending");
				end else begin
					e = exp_q.pop_front();
					check(rom_wr.addr == e[39:16] && rom_wr.data == e[15:0],
					      $sformatf("rom_wr %h/%h, expected %h/%h", rom_wr.addr,
					                rom_wr.data, e[39:16], e[15:0]));
				end
			end

			// Wait held until both acks match the toggle
			if (prev_beat) begin
				check(stream_wait, "stream_wait not raised after a beat");
			end else if (prev_wait) begin
				check(stream_wait == !(prev_ack_d == prev_req && prev_ack_s == prev_req),
				      $sformatf("stream_wait %b against acks", stream_wait));
			end else begin
				check(!stream_wait, "stream_wait high with no beat in flight");
			end

			if (prev_cart && !cart) begin
				a = 24'(beats * 2);
				check(populous == pop[a[9]], $sformatf("populous %b", populous));
				check(sgx == exp_sgx, $sformatf("sgx %b, expected %b", sgx, exp_sgx));
				check(header_present == a[9], "header_present wrong");
				check(rom_size == a[23:16], $sformatf("rom_size %h", rom_size));
			end

			// Cheat side
			check(cheat_reset == exp_reset, $sformatf("cheat_reset %b", cheat_reset));
			check(cheat_valid == exp_valid, $sformatf("cheat_valid %b", cheat_valid));
			if (cheat_valid) begin
				valid_cnt++;
				check(cheat.f.flags == {cw[1], cw[0]} && cheat.f.addr == {cw[3], cw[2]}
				      && cheat.f.compare == {cw[5], cw[4]}
				      && cheat.f.replace == {cw[7], cw[6]},
				      $sformatf("cheat record %h", cheat));
			end
			exp_reset = ctl.download && stream.wr && stream.addr == 25'd0;
			exp_valid = 1'b0;
			if (ctl.download && ctl.index == 8'hFF && stream.wr && !stream.addr[0]) begin
				cw[stream.addr[3:1]] = stream.data;
				if (stream.addr[3:0] == 4'd14) begin
					exp_valid = 1'b1;
					rec_cnt++;
				end
			end

			// Fetch return, ready drops after the strobe and rises with the data
			if (rd_pend && !rd_low) begin
				check(!fetch_rdy, "fetch_rdy stayed high after a read strobe");
				rd_low = 1'b1;
			end else if (rd_pend) begin
				if (fetch_rdy) begin
					check(fetch_data == rd_exp,
					      $sformatf("fetch_data %h, expected %h", fetch_data, rd_exp));
					rd_pend = 1'b0;
				end
			end else begin
				check(fetch_rdy, "fetch_rdy low with no read in flight");
			end
			if (fetch_rd) begin
				a = 24'(beats * 2); // Final address of the last image
				want = ROM_AW'(fetch_addr) + (a[9] ? 24'd512 : 24'd0);
				check(ddr_rd.rd == !use_sdram && sdr_rd.rd == use_sdram,
				      "read strobe reached the wrong memory");
				check((use_sdram ? sdr_rd.addr : ddr_rd.addr) == want,
				      $sformatf("read address, expected %h", want));
				rd_pend = 1'b1;
				rd_low = 1'b0;
				rd_exp = want[7:0] ^ want[15:8] ^ want[23:16]
				         ^ (use_sdram ? 8'hC3 : 8'h3C);
			end

			prev_cart = cart;
			prev_beat = cart && stream.wr;
			prev_wait = stream_wait;
			prev_req = rom_wr.req;
			prev_ack_d = ddr_wr_ack;
			prev_ack_s = sdr_wr_ack;
		end
	end

	// ==============================
	// Reporting
	// ==============================

	task automatic test_done(input string name);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d writes never reached the memories", exp_q.size());
		end
		if (valid_cnt != rec_cnt) begin
			errors++;
			$display("cheat_valid pulsed %0d times for %0d records", valid_cnt, rec_cnt);
		end
		tests++;
		if (errors != err_mark) begin
			failed++;
		end
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
		err_mark = errors;
	endtask

	task automatic summary();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks,
		         errors);
	endtask

endmodule

// ==== bench/tb_top.sv ====
// Loader testbench top
`timescale 1ns/100ps

module tb_top
	import tgfx_stream_pkg::*;
	import tgfx_rom_pkg::*;
();

	localparam int FETCHES = 40;
	localparam int PLANNED = ('h2400 + 'h2600 + 'h2400 + 'h10200) / 2 + 32 + 2 * FETCHES;
	localparam int LIMIT   = 20 * PLANNED + 500;

	logic                clk_sys;
	logic                arst_n;
	stream_word_t        stream;
	stream_ctl_t         ctl;
	logic                swap_bits;
	logic                use_sdram;
	logic                ddr_wr_ack;
	logic                sdr_wr_ack;
	rom_wr_t             rom_wr;
	logic                stream_wait;
	logic                populous;
	logic                sgx;
	logic [7:0]          rom_size;
	logic                header_present;
	cheat_rec_t          cheat;
	logic                cheat_valid;
	logic                cheat_reset;
	logic                fetch_rd;
	logic [FETCH_AW-1:0] fetch_addr;
	logic [7:0]          fetch_data;
	logic                fetch_rdy;
	rom_rd_t             ddr_rd;
	rom_rd_t             sdr_rd;
	logic                ddr_rd_rdy;
	logic                sdr_rd_rdy;
	logic [7:0]          ddr_rd_data;
	logic [7:0]          sdr_rd_data;

	int          seed = 60;
	int          cycles = 0;
	logic [1:0]  wr_ack = 2'b00;  // Index 0 DDR, 1 SDRAM
	int          ack_cnt[2] = '{0, 0};
	logic [1:0]  rd_rdy = 2'b11;  // Idle memory holds ready high
	logic [7:0]  rd_data[2] = '{8'h00, 8'h00};
	int          rd_cnt[2] = '{0, 0};
	logic [23:0] rd_addr_q[2];
	logic [15:0] title[4] = '{16'h4F50, 16'h5550, 16'h4F4C, 16'h5355};

	tb_clock i_tb_clock (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	tgfx_loader_top i_tgfx_loader_top (.*);

	tb_checker chk (.*);

	assign ddr_wr_ack  = wr_ack[0];
	assign sdr_wr_ack  = wr_ack[1];
	assign ddr_rd_rdy  = rd_rdy[0];
	assign sdr_rd_rdy  = rd_rdy[1];
	assign ddr_rd_data = rd_data[0];
	assign sdr_rd_data = rd_data[1];

	function automatic int rand_delay();
		return 1 + int'($unsigned($random(seed)) % 32'd4);
	endfunction

	function automatic logic [15:0] reverse16(input logic [15:0] w);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = w[15-i];
		end
		return r;
	endfunction

	// ==============================
	// Memory models
	// ==============================

	always @(posedge clk_sys) begin
		for (int m = 0; m < 2; m++) begin
			if (ack_cnt[m] != 0) begin
				if (ack_cnt[m] == 1) begin
					wr_ack[m] <= rom_wr.req; // Write finished
				end
				ack_cnt[m] <= ack_cnt[m] - 1;
			end else if (arst_n && wr_ack[m] != rom_wr.req) begin
				ack_cnt[m] <= rand_delay();
			end
		end
	end

	always @(posedge clk_sys) begin : read_model
		rom_rd_t p;
		for (int m = 0; m < 2; m++) begin
			p = (m == 1) ? sdr_rd : ddr_rd;
			if (arst_n && p.rd) begin
				rd_rdy[m]    <= 1'b0;
				rd_cnt[m]    <= rand_delay();
				rd_addr_q[m] <= p.addr;
			end else if (rd_cnt[m] != 0) begin
				if (rd_cnt[m] == 1) begin
					rd_rdy[m]  <= 1'b1;
					rd_data[m] <= rd_addr_q[m][7:0] ^ rd_addr_q[m][15:8]
					              ^ rd_addr_q[m][23:16] ^ ((m == 1) ? 8'hC3 : 8'h3C);
				end
				rd_cnt[m] <= rd_cnt[m] - 1;
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	task automatic send_beat(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		stream <= '{wr: 1'b1, addr: a, data: d};
		@(posedge clk_sys);
		stream.wr <= 1'b0;
		do @(posedge clk_sys); while (stream_wait); // Host holds off
	endtask

	task automatic load_image(input logic [7:0] idx, input logic swap, input int nbytes,
	                          input logic with_title, input logic hdr);
		int          base;
		logic [15:0] w;
		base = hdr ? 'h2120 : 'h1F20;
		@(posedge clk_sys);
		ctl       <= '{download: 1'b1, index: idx};
		swap_bits <= swap;
		repeat (2) @(posedge clk_sys);
		for (int a = 0; a < nbytes; a += 2) begin
			w = 16'($random(seed));
			if (with_title && a >= base + 6 && a <= base + 12) begin
				w = swap ? reverse16(title[(a - base - 6) / 2]) : title[(a - base - 6) / 2];
			end
			send_beat(25'(a), w);
		end
		@(posedge clk_sys);
		ctl.download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic load_cheats(input int records);
		@(posedge clk_sys);
		ctl <= '{download: 1'b1, index: 8'hFF};
		for (int a = 0; a < records * 16; a += 2) begin
			send_beat(25'(a), 16'($random(seed)));
		end
		@(posedge clk_sys);
		ctl.download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_fetches(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			fetch_rd   <= 1'b1;
			fetch_addr <= FETCH_AW'($random(seed));
			use_sdram  <= 1'($random(seed));
			@(posedge clk_sys);
			fetch_rd  <= 1'b0;
			use_sdram <= 1'($random(seed)); // Choice may move while the read is in flight
			do @(posedge clk_sys); while (!fetch_rdy);
		end
	endtask

	initial begin
		stream     = '0;
		ctl        = '0;
		swap_bits  = 1'b0;
		use_sdram  = 1'b0;
		fetch_rd   = 1'b0;
		fetch_addr = '0;
		@(posedge arst_n);
		repeat (2) @(posedge clk_sys);
		load_image(8'h00, 1'b0, 'h2400, 1'b1, 1'b0);
		chk.test_done("plain image with title");
		load_image(8'h02, 1'b1, 'h2600, 1'b1, 1'b1);
		chk.test_done("swapped SuperGrafx image with header and title");
		run_fetches(FETCHES);
		chk.test_done("fetches with header offset");
		load_image(8'h22, 1'b0, 'h2400, 1'b0, 1'b0);
		chk.test_done("image without title");
		run_fetches(FETCHES);
		chk.test_done("fetches without header");
		// Past 64 KB so the size byte is not zero
		load_image(8'h01, 1'b1, 'h10200, 1'b0, 1'b1);
		chk.test_done("large swapped image with header, no title");
		load_cheats(2);
		chk.test_done("cheat records");
		repeat (4) @(posedge clk_sys);
		chk.summary();
		if (chk.errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Run limit from the planned beat count
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
hw/tgfx_stream_pkg.sv
hw/tgfx_rom_pkg.sv
hw/rom_loader.sv
hw/cheat_loader.sv
hw/rom_fetch_router.sv
hw/tgfx_loader_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_top -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "\*\* FAIL \*\*" sim.log \
	&& { echo "simulation failed, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
